// File: files.f
+incdir+verilog
verilog/ddr4_mon_pkg.sv
verilog/ddr4_cmd_decode.sv
verilog/ddr4_bank_tracker.sv
verilog/ddr4_cmd_stats.sv
verilog/ddr4_wb_regs.sv
verilog/ddr4_ca_monitor.sv
tb/tb_clkgen.sv
tb/ddr4_mon_props.sv
tb/tb_ddr4_ca_monitor.sv

// File: tb/tb_ddr4_ca_monitor.sv
`timescale 1ns/10ps
`include "ddr4_mon_params.svh"

module tb_ddr4_ca_monitor
    import ddr4_mon_pkg::*;
;

    localparam int N_FIX   = 16;
    localparam int N_RAND  = 40;
    localparam int N_REGS  = 9;
    localparam int N_CHK   = 8;
    localparam int RST_CYC = 16;
    localparam int LIMIT   = 4 * (N_FIX + N_RAND + N_CHK * N_REGS * 4 + RST_CYC);

    logic       c0_ddr4_ck_t;
    logic       rst_n;
    logic       cs_n;
    logic       act_n;
    ddr4_adr_t  adr;
    logic [1:0] bg;
    logic [1:0] ba;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_adr_t    wb_adr;
    wb_dat_t    wb_dat_w;
    wb_dat_t    wb_dat_r;
    logic       wb_ack;

    integer     seed;
    int         cyc_count;
    wb_dat_t    exp_now [0:N_REGS-1];

    // Reference model state, counters in register order act..other
    mon_cnt_t          m_cnt [0:5];
    mon_cnt_t          m_err;
    logic [`DDR4_BANKS-1:0] m_open;
    logic              m_dir;

    tb_clkgen i_clkgen (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n)
    );

    ddr4_ca_monitor i_dut (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .cs_n         (cs_n),
        .act_n        (act_n),
        .adr          (adr),
        .bg           (bg),
        .ba           (ba),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack)
    );

    // Row layout {cs_n, act_n, adr[16:0], bg, ba}, code on adr[16:14]
    function automatic logic [22:0] cmd_row(input logic cs, input logic act,
                                            input logic [2:0] code, input logic a10,
                                            input logic [3:0] bank);
        return {cs, act, code, 3'b000, a10, 10'h000, bank};
    endfunction

    // ==============================
    // Stimulus and expected values
    // ==============================

    localparam logic [22:0] STIM [0:N_FIX-1] = '{
        cmd_row(0, 0, 3'b000, 0, 4'd5),  cmd_row(0, 1, 3'b100, 0, 4'd5),
        cmd_row(0, 1, 3'b101, 0, 4'd5),  cmd_row(0, 1, 3'b010, 0, 4'd5),
        // WR to closed bank, double ACT, code 011, deselected ACT
        cmd_row(0, 1, 3'b100, 0, 4'd3),  cmd_row(0, 0, 3'b000, 0, 4'd7),
        cmd_row(0, 0, 3'b000, 0, 4'd7),  cmd_row(0, 1, 3'b011, 0, 4'd0),
        cmd_row(1, 0, 3'b000, 0, 4'd2),
        cmd_row(0, 0, 3'b000, 0, 4'd0),  cmd_row(0, 0, 3'b000, 0, 4'd15),
        cmd_row(0, 1, 3'b010, 1, 4'd0),
        // MRS, ZQC, REF, NOP
        cmd_row(0, 1, 3'b000, 0, 4'd0),  cmd_row(0, 1, 3'b110, 0, 4'd0),
        cmd_row(0, 1, 3'b001, 0, 4'd0),  cmd_row(0, 1, 3'b111, 0, 4'd0)
    };

    // Row count that ends each checkpoint
    localparam int CHK_END [1:5] = '{4, 9, 11, 12, 16};

    // act, wr, rd, pre, ref, other, err, open, status
    localparam wb_dat_t EXP_TAB [0:5][0:N_REGS-1] = '{
        '{0, 0, 0, 0, 0, 0, 0, 32'h0000, 0},
        '{1, 1, 1, 1, 0, 0, 0, 32'h0000, 0},
        '{3, 2, 1, 1, 0, 0, 3, 32'h0080, 1},
        '{5, 2, 1, 1, 0, 0, 3, 32'h8081, 1},
        '{5, 2, 1, 2, 0, 0, 3, 32'h0000, 1},
        '{5, 2, 1, 2, 1, 2, 3, 32'h0000, 1}
    };

    localparam string REG_NAME [0:N_REGS-1] = '{
        "act", "wr", "rd", "pre", "ref", "other", "err", "open", "status"
    };

    task automatic check_val(input string what, input wb_dat_t exp, input wb_dat_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, what, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "Register mismatch");
        end
    endtask

    task automatic model_step(input logic [22:0] r);
        logic [2:0] code;
        int         bank;
        code = r[20:18];
        bank = r[3:0];
        if (!r[22]) begin
            if (!r[21]) begin
                if (m_open[bank]) begin
                    m_err++;
                end
                m_open[bank] = 1'b1;
                m_cnt[0]++;
            end else begin
                case (code)
                    3'b000, 3'b110: m_cnt[5]++;
                    3'b001:         m_cnt[4]++;
                    3'b010: begin
                        m_cnt[3]++;
                        if (r[14]) begin
                            m_open = '0;
                        end else begin
                            m_open[bank] = 1'b0;
                        end
                    end
                    3'b100, 3'b101: begin
                        m_cnt[(code == 3'b100) ? 1 : 2]++;
                        if (!m_open[bank]) begin
                            m_err++;
                        end
                        m_dir = (code == 3'b100);
                    end
                    3'b011:  m_err++;
                    default: ;
                endcase
            end
        end
    endtask

    task automatic drive_row(input logic [22:0] r);
        @(posedge c0_ddr4_ck_t);
        #1;
        cs_n  = r[22];
        act_n = r[21];
        adr   = r[20:4];
        bg    = r[3:2];
        ba    = r[1:0];
        model_step(r);
    endtask

    // Deselect, then let the two-stage pipeline drain
    task automatic settle();
        drive_row({1'b1, 22'h0});
        repeat (4) @(posedge c0_ddr4_ck_t);
    endtask

    task automatic wb_access(input logic we, input wb_adr_t a, input wb_dat_t d,
                             output wb_dat_t q);
        @(posedge c0_ddr4_ck_t);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = a;
        wb_dat_w = d;
        do begin
            @(posedge c0_ddr4_ck_t);
            #1;
        end while (!wb_ack);
        q = wb_dat_r;
        // Master drops the strobe after the edge that samples ack
        @(posedge c0_ddr4_ck_t);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic check_regs(input string tag);
        wb_dat_t q;
        for (int i = 0; i < N_REGS; i++) begin
            wb_access(1'b0, wb_adr_t'(i), '0, q);
            check_val($sformatf("%s %s", tag, REG_NAME[i]), exp_now[i], q);
        end
    endtask

    task automatic load_model_exp();
        for (int i = 0; i < 6; i++) begin
            exp_now[i] = wb_dat_t'(m_cnt[i]);
        end
        exp_now[6] = wb_dat_t'(m_err);
        exp_now[7] = wb_dat_t'(m_open);
        exp_now[8] = wb_dat_t'(m_dir);
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        wb_dat_t q;
        int      row;
        int      r32;
        cs_n     = 1'b1;
        act_n    = 1'b1;
        adr      = '0;
        bg       = '0;
        ba       = '0;
        // Live strobe during reset, the slave must not answer it
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        seed     = 32'h5685f901;
        for (int i = 0; i < 6; i++) begin
            m_cnt[i] = '0;
        end
        m_err  = '0;
        m_open = '0;
        m_dir  = 1'b0;
        repeat (RST_CYC - 2) @(posedge c0_ddr4_ck_t);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wait (rst_n === 1'b1);

        exp_now = EXP_TAB[0];
        check_regs("reset");
        row = 0;
        for (int c = 1; c <= 5; c++) begin
            while (row < CHK_END[c]) begin
                drive_row(STIM[row]);
                row++;
            end
            settle();
            exp_now = EXP_TAB[c];
            check_regs($sformatf("point %0d", c));
        end

        for (int i = 0; i < N_RAND; i++) begin
            r32 = $random(seed);
            drive_row(r32[22:0]);
        end
        settle();
        load_model_exp();
        check_regs("random");

        // Any write clears counters, bank state stays
        wb_access(1'b1, `REG_ACT, 32'h0000_0001, q);
        for (int i = 0; i < 6; i++) begin
            m_cnt[i] = '0;
        end
        m_err = '0;
        settle();
        load_model_exp();
        check_regs("clear");
        wb_access(1'b0, 4'hf, '0, q);
        check_val("unmapped", '0, q);

        if (i_dut.i_regs.i_props.fail_count != 0) begin
            $display("Wishbone handshake assertions failed %0d times",
                     i_dut.i_regs.i_props.fail_count);
            $display("FAIL: see errors above");
            $fatal(1, "Assertion failures");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

    initial begin
        cyc_count = 0;
        while (cyc_count < LIMIT) begin
            @(posedge c0_ddr4_ck_t);
            cyc_count++;
        end
        $display("Simulation hung, no completion within %0d cycles", LIMIT);
        $display("FAIL: see errors above");
        $fatal(1, "Timeout");
    end

endmodule

// File: tb/ddr4_mon_props.sv
`timescale 1ns/10ps

module ddr4_mon_props (
    input logic c0_ddr4_ck_t,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack
);

    int fail_count = 0;

    // Ack only answers a live strobe
    ack_needs_stb: assert property (@(posedge c0_ddr4_ck_t) wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("wb_ack high without wb_cyc and wb_stb");
            fail_count++;
        end

    ack_one_cycle: assert property (@(posedge c0_ddr4_ck_t) wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack high for two cycles in a row");
            fail_count++;
        end

    // Synchronous reset, so ack is low by the next edge
    ack_low_in_reset: assert property (@(posedge c0_ddr4_ck_t) !rst_n |=> !wb_ack)
        else begin
            $error("wb_ack high during reset");
            fail_count++;
        end

endmodule

bind ddr4_wb_regs ddr4_mon_props i_props (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .rst_n        (rst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack)
);

// File: tb/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
    output logic c0_ddr4_ck_t,
    output logic rst_n
);

    localparam real HALF_NS    = 4.0;
    localparam int  RST_CYCLES = 16;

    initial begin
        c0_ddr4_ck_t = 1'b0;
        forever begin
            #(HALF_NS) c0_ddr4_ck_t = ~c0_ddr4_ck_t;
        end
    end

    // Release just after an edge, away from the sampling point
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge c0_ddr4_ck_t);
        #1;
        rst_n = 1'b1;
    end

endmodule

// File: verilog/ddr4_ca_monitor.sv
`timescale 1ns/10ps
`include "ddr4_mon_params.svh"

module ddr4_ca_monitor
    import ddr4_mon_pkg::*;
(
    input  logic       c0_ddr4_ck_t,
    input  logic       rst_n,
    input  logic       cs_n,
    input  logic       act_n,
    input  ddr4_adr_t  adr,
    input  logic [1:0] bg,
    input  logic [1:0] ba,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_adr_t    wb_adr,
    input  wb_dat_t    wb_dat_w,
    output wb_dat_t    wb_dat_r,
    output logic       wb_ack
);

    // Decoded command stream
    logic      cmd_valid;
    ddr4_cmd_e cmd;
    bank_id_t  cmd_bank;
    logic      cmd_a10;

    // Results toward the register port
    logic [`DDR4_BANKS-1:0] open_mask;
    mon_cnt_t err_count;
    mon_cnt_t act_count;
    mon_cnt_t wr_count;
    mon_cnt_t rd_count;
    mon_cnt_t pre_count;
    mon_cnt_t ref_count;
    mon_cnt_t other_count;
    logic     wr_dir;
    logic     clear;

    ddr4_cmd_decode i_decode (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .cs_n         (cs_n),
        .act_n        (act_n),
        .adr          (adr),
        .bg           (bg),
        .ba           (ba),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_bank     (cmd_bank),
        .cmd_a10      (cmd_a10)
    );

    ddr4_bank_tracker i_tracker (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_bank     (cmd_bank),
        .cmd_a10      (cmd_a10),
        .clear        (clear),
        .open_mask    (open_mask),
        .err_count    (err_count)
    );

    ddr4_cmd_stats i_stats (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .clear        (clear),
        .act_count    (act_count),
        .wr_count     (wr_count),
        .rd_count     (rd_count),
        .pre_count    (pre_count),
        .ref_count    (ref_count),
        .other_count  (other_count),
        .wr_dir       (wr_dir)
    );

    ddr4_wb_regs i_regs (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .act_count    (act_count),
        .wr_count     (wr_count),
        .rd_count     (rd_count),
        .pre_count    (pre_count),
        .ref_count    (ref_count),
        .other_count  (other_count),
        .err_count    (err_count),
        .open_mask    (open_mask),
        .wr_dir       (wr_dir),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .clear        (clear)
    );

endmodule

// File: verilog/ddr4_wb_regs.sv
`timescale 1ns/10ps
`include "ddr4_mon_params.svh"

module ddr4_wb_regs
    import ddr4_mon_pkg::*;
(
    input  logic                   c0_ddr4_ck_t,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  wb_adr_t                wb_adr,
    input  wb_dat_t                wb_dat_w,
    input  mon_cnt_t               act_count,
    input  mon_cnt_t               wr_count,
    input  mon_cnt_t               rd_count,
    input  mon_cnt_t               pre_count,
    input  mon_cnt_t               ref_count,
    input  mon_cnt_t               other_count,
    input  mon_cnt_t               err_count,
    input  logic [`DDR4_BANKS-1:0] open_mask,
    input  logic                   wr_dir,
    output wb_dat_t                wb_dat_r,
    output logic                   wb_ack,
    output logic                   clear
);

    logic    access;
    logic    wr_any;
    wb_dat_t rd_mux;

    // New cycle only while ack is low, so ack never lasts two clocks
    assign access = wb_cyc & wb_stb & ~wb_ack;

    // Write data is don't-care, a write of any value clears
    assign wr_any = access & wb_we;

    // ==============================
    // Register map
    // ==============================

    always_comb begin
        case (wb_adr)
            `REG_ACT:    rd_mux = wb_dat_t'(act_count);
            `REG_WR:     rd_mux = wb_dat_t'(wr_count);
            `REG_RD:     rd_mux = wb_dat_t'(rd_count);
            `REG_PRE:    rd_mux = wb_dat_t'(pre_count);
            `REG_REF:    rd_mux = wb_dat_t'(ref_count);
            `REG_OTHER:  rd_mux = wb_dat_t'(other_count);
            `REG_ERR:    rd_mux = wb_dat_t'(err_count);
            `REG_OPEN:   rd_mux = wb_dat_t'(open_mask);
            `REG_STATUS: rd_mux = wb_dat_t'(wr_dir);
            default:     rd_mux = '0;
        endcase
    end

    // ==============================
    // Handshake
    // ==============================

    always_ff @(posedge c0_ddr4_ck_t) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            clear  <= 1'b0;
        end else begin
            wb_ack <= access;
            // Pulse lines up with the write ack
            clear  <= wr_any;
        end
    end

    always_ff @(posedge c0_ddr4_ck_t) begin
        if (access && !wb_we) begin
            wb_dat_r <= rd_mux;
        end
    end

endmodule

// File: verilog/ddr4_cmd_stats.sv
`timescale 1ns/10ps

module ddr4_cmd_stats
    import ddr4_mon_pkg::*;
(
    input  logic      c0_ddr4_ck_t,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  ddr4_cmd_e cmd,
    input  logic      clear,
    output mon_cnt_t  act_count,
    output mon_cnt_t  wr_count,
    output mon_cnt_t  rd_count,
    output mon_cnt_t  pre_count,
    output mon_cnt_t  ref_count,
    output mon_cnt_t  other_count,
    output logic      wr_dir
);

    localparam int N_CNT    = 6;
    localparam int IX_ACT   = 0;
    localparam int IX_WR    = 1;
    localparam int IX_RD    = 2;
    localparam int IX_PRE   = 3;
    localparam int IX_REF   = 4;
    localparam int IX_OTHER = 5;

    mon_cnt_t         cnt [N_CNT];
    logic [N_CNT-1:0] hit;

    // One-hot counter select, NOP and ILL hit nothing
    always_comb begin
        hit = '0;
        if (cmd_valid) begin
            case (cmd)
                CMD_ACT:          hit[IX_ACT]   = 1'b1;
                CMD_WR:           hit[IX_WR]    = 1'b1;
                CMD_RD:           hit[IX_RD]    = 1'b1;
                CMD_PRE:          hit[IX_PRE]   = 1'b1;
                CMD_REF:          hit[IX_REF]   = 1'b1;
                CMD_MRS, CMD_ZQC: hit[IX_OTHER] = 1'b1;
                default:          hit = '0;
            endcase
        end
    end

    always_ff @(posedge c0_ddr4_ck_t) begin
        if (!rst_n) begin
            for (int i = 0; i < N_CNT; i++) begin
                cnt[i] <= '0;
            end
            wr_dir <= 1'b0;
        end else begin
            for (int i = 0; i < N_CNT; i++) begin
                if (clear) begin
                    cnt[i] <= '0;
                end else if (hit[i]) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
            // Direction survives a counter clear
            if (hit[IX_WR]) begin
                wr_dir <= 1'b1;
            end else if (hit[IX_RD]) begin
                wr_dir <= 1'b0;
            end
        end
    end

    assign act_count   = cnt[IX_ACT];
    assign wr_count    = cnt[IX_WR];
    assign rd_count    = cnt[IX_RD];
    assign pre_count   = cnt[IX_PRE];
    assign ref_count   = cnt[IX_REF];
    assign other_count = cnt[IX_OTHER];

endmodule

// File: verilog/ddr4_bank_tracker.sv
`timescale 1ns/10ps
`include "ddr4_mon_params.svh"

module ddr4_bank_tracker
    import ddr4_mon_pkg::*;
(
    input  logic                   c0_ddr4_ck_t,
    input  logic                   rst_n,
    input  logic                   cmd_valid,
    input  ddr4_cmd_e              cmd,
    input  bank_id_t               cmd_bank,
    input  logic                   cmd_a10,
    input  logic                   clear,
    output logic [`DDR4_BANKS-1:0] open_mask,
    output mon_cnt_t               err_count
);

    bank_state_e bank_st [`DDR4_BANKS];
    logic        err_hit;

    // ==============================
    // Protocol checks
    // ==============================

    always_comb begin
        err_hit = 1'b0;
        if (cmd_valid) begin
            case (cmd)
                CMD_ACT:        err_hit = (bank_st[cmd_bank] == OPEN);
                CMD_WR, CMD_RD: err_hit = (bank_st[cmd_bank] == CLOSED);
                CMD_ILL:        err_hit = 1'b1;
                default:        err_hit = 1'b0;
            endcase
        end
    end

    always_ff @(posedge c0_ddr4_ck_t) begin
        if (!rst_n) begin
            for (int i = 0; i < `DDR4_BANKS; i++) begin
                bank_st[i] <= CLOSED;
            end
            err_count <= '0;
        end else begin
            if (cmd_valid) begin
                case (cmd)
                    // A repeated activate leaves the bank open
                    CMD_ACT: bank_st[cmd_bank] <= OPEN;
                    CMD_PRE: begin
                        if (cmd_a10) begin
                            // PREA
                            for (int i = 0; i < `DDR4_BANKS; i++) begin
                                bank_st[i] <= CLOSED;
                            end
                        end else begin
                            bank_st[cmd_bank] <= CLOSED;
                        end
                    end
                    // REF assumes the banks are already precharged
                    default: ;
                endcase
            end
            if (clear) begin
                err_count <= '0;
            end else if (err_hit) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `DDR4_BANKS; i++) begin
            open_mask[i] = (bank_st[i] == OPEN);
        end
    end

endmodule

// File: verilog/ddr4_cmd_decode.sv
`timescale 1ns/10ps

module ddr4_cmd_decode
    import ddr4_mon_pkg::*;
(
    input  logic      c0_ddr4_ck_t,
    input  logic      rst_n,
    input  logic      cs_n,
    input  logic      act_n,
    input  ddr4_adr_t adr,
    input  logic [1:0] bg,
    input  logic [1:0] ba,
    output logic      cmd_valid,
    output ddr4_cmd_e cmd,
    output bank_id_t  cmd_bank,
    output logic      cmd_a10
);

    // ==============================
    // Pin sample stage
    // ==============================

    logic       cs_n_q;
    logic       act_n_q;
    ddr4_adr_t  adr_q;
    logic [1:0] bg_q;
    logic [1:0] ba_q;

    // Deselected after reset so nothing decodes from stale pins
    always_ff @(posedge c0_ddr4_ck_t) begin
        if (!rst_n) begin
            cs_n_q <= 1'b1;
        end else begin
            cs_n_q <= cs_n;
        end
    end

    always_ff @(posedge c0_ddr4_ck_t) begin
        act_n_q <= act_n;
        adr_q   <= adr;
        bg_q    <= bg;
        ba_q    <= ba;
    end

    // ==============================
    // Command classification
    // ==============================

    ddr4_cmd_e cmd_d;

    always_comb begin
        if (!act_n_q) begin
            cmd_d = CMD_ACT;
        end else begin
            // RAS_n, CAS_n, WE_n on A16..A14
            case (adr_q[`DDR4_ADR_W-1 -: 3])
                3'b000:  cmd_d = CMD_MRS;
                3'b001:  cmd_d = CMD_REF;
                3'b010:  cmd_d = CMD_PRE;
                3'b100:  cmd_d = CMD_WR;
                3'b101:  cmd_d = CMD_RD;
                3'b110:  cmd_d = CMD_ZQC;
                3'b111:  cmd_d = CMD_NOP;
                default: cmd_d = CMD_ILL;
            endcase
        end
    end

    always_ff @(posedge c0_ddr4_ck_t) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= ~cs_n_q;
        end
    end

    // Payload follows the sample stage every cycle
    always_ff @(posedge c0_ddr4_ck_t) begin
        cmd      <= cmd_d;
        cmd_bank <= {bg_q, ba_q};
        cmd_a10  <= adr_q[10];
    end

endmodule

// File: verilog/ddr4_mon_pkg.sv
`include "ddr4_mon_params.svh"

package ddr4_mon_pkg;

    // Decoded command, one per selected clock
    typedef enum logic [3:0] {
        CMD_MRS = 4'd0,
        CMD_REF = 4'd1,
        CMD_PRE = 4'd2,
        CMD_ACT = 4'd3,
        CMD_WR  = 4'd4,
        CMD_RD  = 4'd5,
        CMD_ZQC = 4'd6,
        CMD_NOP = 4'd7,
        // Reserved code 011 with act_n high
        CMD_ILL = 4'd8
    } ddr4_cmd_e;

    typedef enum logic {
        CLOSED = 1'b0,
        OPEN   = 1'b1
    } bank_state_e;

    typedef logic [`DDR4_ADR_W-1:0]  ddr4_adr_t;
    typedef logic [`DDR4_BANK_W-1:0] bank_id_t;
    typedef logic [`MON_CNT_W-1:0]   mon_cnt_t;
    typedef logic [`WB_ADR_W-1:0]    wb_adr_t;
    typedef logic [`WB_DAT_W-1:0]    wb_dat_t;

endpackage

// File: verilog/ddr4_mon_params.svh
`ifndef DDR4_MON_PARAMS_SVH
`define DDR4_MON_PARAMS_SVH

// ==============================
// DDR4 pin widths
// ==============================

// A16..A0, A16..A14 double as RAS_n/CAS_n/WE_n
`define DDR4_ADR_W   17
// Bank group in the upper two bits
`define DDR4_BANK_W  4
`define DDR4_BANKS   16

// ==============================
// Register port
// ==============================

`define MON_CNT_W    16
`define WB_ADR_W     4
`define WB_DAT_W     32

// Word offsets
`define REG_ACT      4'd0
`define REG_WR       4'd1
`define REG_RD       4'd2
`define REG_PRE      4'd3
`define REG_REF      4'd4
`define REG_OTHER    4'd5
`define REG_ERR      4'd6
`define REG_OPEN     4'd7
`define REG_STATUS   4'd8

`endif
